/* verilog/wb_settings.svh */
`ifndef WB_SETTINGS_SVH
`define WB_SETTINGS_SVH

// datapath and address width
`define WB_XLEN 32

// architectural register file
`define WB_RADDR_W 5
`define WB_NREGS 32

`endif

/* verilog/wb_pkg.sv */
`include "wb_settings.svh"

package wb_pkg;

    // decoded micro-op flags
    // cond[0] on a divide picks the remainder, cond[2] on a memory op marks a store
    typedef struct packed {
        logic       is_csr;
        logic       is_div;
        logic       is_mem;
        logic [3:0] cond;
    } uop_t;

    // one instruction leaving execute
    typedef struct packed {
        logic [`WB_XLEN-1:0]    pc;
        logic [`WB_XLEN-1:0]    inst;
        uop_t                   uop;
        logic [`WB_XLEN-1:0]    result;
        logic                   result_valid;
        logic [`WB_RADDR_W-1:0] rd;
    } lane_in_t;

    // results of the long-latency units, seen by both lanes
    typedef struct packed {
        logic [`WB_XLEN-1:0] quotient;
        logic [`WB_XLEN-1:0] remainder;
        logic                div_ready;
        logic [`WB_XLEN-1:0] dcache_data;
        logic                dcache_ready;
        logic [`WB_XLEN-1:0] csr_data;
        logic                csr_ready;
    } unit_res_t;

    typedef struct packed {
        logic                   we;
        logic [`WB_RADDR_W-1:0] rd;
        logic [`WB_XLEN-1:0]    data;
    } rf_write_t;

    // retire trace record
    typedef struct packed {
        logic [`WB_XLEN-1:0]    pc;
        logic [`WB_XLEN-1:0]    inst;
        logic [3:0]             rf_wen;
        logic [`WB_RADDR_W-1:0] rf_wnum;
        logic [`WB_XLEN-1:0]    rf_wdata;
        logic                   valid;
    } wb_debug_t;

endpackage

/* verilog/exc_pkg.sv */
`include "wb_settings.svh"

package exc_pkg;

    // LoongArch exception codes
    typedef enum logic [6:0] {
        INT  = 7'h00,
        PIL  = 7'h01,
        PIS  = 7'h02,
        PIF  = 7'h03,
        PME  = 7'h04,
        PPI  = 7'h07,
        ADEF = 7'h08,
        ALE  = 7'h09,
        SYS  = 7'h0b,
        BRK  = 7'h0c,
        INE  = 7'h0d,
        IPE  = 7'h0e,
        FPD  = 7'h0f,
        FPE  = 7'h12,
        TLBR = 7'h3f
    } ecode_e;

    // exception state carried down the pipe
    typedef struct packed {
        logic                flag;
        ecode_e              ecode;
        logic [`WB_XLEN-1:0] badv;
        logic [`WB_XLEN-1:0] era;
    } exc_in_t;

    // towards the CSR file and the fetch redirect
    typedef struct packed {
        logic                flush;
        ecode_e              ecode;
        logic [`WB_XLEN-1:0] badv;
        logic                wen_badv;
        logic [`WB_XLEN-1:0] era;
        logic                wen_era;
        logic [18:0]         vppn;
        logic                wen_vppn;
        logic                tlb_refill;
    } exc_commit_t;

endpackage

/* verilog/wb_lane_select.sv */
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_lane_select #(
    parameter bit CSR_CAPABLE = 1'b1
) (
    input  logic              clk,
    input  logic              aresetn,
    input  wb_pkg::lane_in_t  lane,
    input  wb_pkg::unit_res_t units,
    input  logic              allow_in,
    output wb_pkg::rf_write_t wr,
    output wb_pkg::wb_debug_t debug,
    output logic              wait_unit
);
    import wb_pkg::*;

    rf_write_t              wr_next;
    logic                   is_load;
    logic                   we_q;
    logic                   valid_q;
    logic [`WB_RADDR_W-1:0] rd_q;
    logic [`WB_XLEN-1:0]    data_q;
    logic [`WB_XLEN-1:0]    pc_q;
    logic [`WB_XLEN-1:0]    inst_q;

    // stores also carry is_mem but never write back
    assign is_load = lane.uop.is_mem && !lane.uop.cond[2];

    // priority: execute result, csr, divider, load
    always_comb begin
        wr_next   = '0;
        wait_unit = 1'b0;
        if (lane.result_valid) begin
            wr_next.we   = 1'b1;
            wr_next.rd   = lane.rd;
            wr_next.data = lane.result;
        end else if (CSR_CAPABLE && lane.uop.is_csr) begin
            wr_next.we   = units.csr_ready;
            wr_next.rd   = lane.rd;
            wr_next.data = units.csr_data;
            wait_unit    = !units.csr_ready;
        end else if (lane.uop.is_div) begin
            wr_next.we   = units.div_ready;
            wr_next.rd   = lane.rd;
            wr_next.data = lane.uop.cond[0] ? units.remainder : units.quotient;
            wait_unit    = !units.div_ready;
        end else if (is_load) begin
            wr_next.we   = units.dcache_ready;
            wr_next.rd   = lane.rd;
            wr_next.data = units.dcache_data;
            wait_unit    = !units.dcache_ready;
        end
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            we_q    <= 1'b0;
            valid_q <= 1'b0;
        end else begin
            we_q    <= wr_next.we;
            valid_q <= allow_in;
        end
    end

    // payload, sampled every cycle
    always_ff @(posedge clk) begin
        rd_q   <= wr_next.rd;
        data_q <= wr_next.data;
        pc_q   <= lane.pc;
        inst_q <= lane.inst;
    end

    assign wr.we   = we_q;
    assign wr.rd   = rd_q;
    assign wr.data = data_q;

    assign debug.pc       = pc_q;
    assign debug.inst     = inst_q;
    assign debug.rf_wen   = {4{we_q}};
    assign debug.rf_wnum  = rd_q;
    assign debug.rf_wdata = data_q;
    assign debug.valid    = valid_q;

endmodule

/* verilog/exc_commit.sv */
`timescale 1ns/100ps
`include "wb_settings.svh"

module exc_commit (
    input  logic                clk,
    input  logic                aresetn,
    input  exc_pkg::exc_in_t    exc,
    input  logic                cpu_interrupt,
    input  logic [`WB_XLEN-1:0] eentry,
    input  logic [`WB_XLEN-1:0] tlbrentry,
    output exc_pkg::exc_commit_t commit,
    output logic [`WB_XLEN-1:0] entry_pc
);
    import exc_pkg::*;

    logic                set_badv;
    logic                set_vppn;
    logic                flush_q;
    logic                wen_badv_q;
    logic                wen_era_q;
    logic                wen_vppn_q;
    logic                tlb_refill_q;
    ecode_e              ecode_q;
    logic [`WB_XLEN-1:0] badv_q;
    logic [`WB_XLEN-1:0] era_q;
    logic [18:0]         vppn_q;

    // address-related faults update badv, the TLB ones also vppn
    always_comb begin
        set_badv = 1'b0;
        set_vppn = 1'b0;
        case (exc.ecode)
            PIL, PIS, PIF, PME, PPI, TLBR: begin
                set_badv = 1'b1;
                set_vppn = 1'b1;
            end
            ADEF, ALE: begin
                set_badv = 1'b1;
            end
            default: begin
                set_badv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            flush_q      <= 1'b0;
            wen_era_q    <= 1'b0;
            wen_badv_q   <= 1'b0;
            wen_vppn_q   <= 1'b0;
            tlb_refill_q <= 1'b0;
        end else begin
            // interrupts flush and save era like any exception
            flush_q      <= exc.flag | cpu_interrupt;
            wen_era_q    <= exc.flag | cpu_interrupt;
            wen_badv_q   <= exc.flag && set_badv;
            wen_vppn_q   <= exc.flag && set_vppn;
            tlb_refill_q <= exc.flag && (exc.ecode == TLBR);
        end
    end

    always_ff @(posedge clk) begin
        ecode_q <= exc.ecode;
        badv_q  <= exc.badv;
        era_q   <= exc.era;
        vppn_q  <= exc.badv[18:0];
    end

    assign commit.flush      = flush_q;
    assign commit.ecode      = ecode_q;
    assign commit.badv       = badv_q;
    assign commit.wen_badv   = wen_badv_q;
    assign commit.era        = era_q;
    assign commit.wen_era    = wen_era_q;
    assign commit.vppn       = vppn_q;
    assign commit.wen_vppn   = wen_vppn_q;
    assign commit.tlb_refill = tlb_refill_q;

    // refill has its own vector
    assign entry_pc = tlb_refill_q ? tlbrentry : eentry;

endmodule

/* verilog/regfile_2w4r.sv */
`timescale 1ns/100ps
`include "wb_settings.svh"

module regfile_2w4r (
    input  logic                                clk,
    input  logic                                aresetn,
    input  wb_pkg::rf_write_t                   wr0,
    input  wb_pkg::rf_write_t                   wr1,
    input  logic [3:0][`WB_RADDR_W-1:0]         raddr,
    output logic [3:0][`WB_XLEN-1:0]            rdata
);
    localparam int NREAD = 4;

    logic [`WB_XLEN-1:0] regs [`WB_NREGS];

    always_ff @(posedge clk or negedge aresetn) begin
        if (!aresetn) begin
            for (int i = 0; i < `WB_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr0.we && wr0.rd != '0) begin
                regs[wr0.rd] <= wr0.data;
            end
            // lane 1 is younger, so its write lands last
            if (wr1.we && wr1.rd != '0) begin
                regs[wr1.rd] <= wr1.data;
            end
        end
    end

    // asynchronous reads, r0 hardwired
    always_comb begin
        for (int p = 0; p < NREAD; p++) begin
            if (raddr[p] == '0) begin
                rdata[p] = '0;
            end else begin
                rdata[p] = regs[raddr[p]];
            end
        end
    end

endmodule

/* verilog/wb_top.sv */
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_top (
    input  logic                        clk,
    input  logic                        aresetn,

    // execute stage
    input  wb_pkg::lane_in_t            lane0_in,
    input  wb_pkg::lane_in_t            lane1_in,
    input  wb_pkg::unit_res_t           units,
    output logic                        allow_in,

    // exception commit
    input  exc_pkg::exc_in_t            exc,
    input  logic                        cpu_interrupt,
    input  logic [`WB_XLEN-1:0]         eentry,
    input  logic [`WB_XLEN-1:0]         tlbrentry,
    output exc_pkg::exc_commit_t        commit,
    output logic [`WB_XLEN-1:0]         entry_pc,

    // register file read ports
    input  logic [3:0][`WB_RADDR_W-1:0] raddr,
    output logic [3:0][`WB_XLEN-1:0]    rdata,

    // retire trace
    output wb_pkg::wb_debug_t           debug0,
    output wb_pkg::wb_debug_t           debug1
);
    import wb_pkg::*;

    rf_write_t wr0;
    rf_write_t wr1;
    logic      wait0;
    logic      wait1;

    // stall while either lane still waits on a unit
    assign allow_in = !(wait0 || wait1);

    wb_lane_select #(
        .CSR_CAPABLE(1'b1)
    ) lane0_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .lane      (lane0_in),
        .units     (units),
        .allow_in  (allow_in),
        .wr        (wr0),
        .debug     (debug0),
        .wait_unit (wait0)
    );

    // csr access is single-issue through lane 0
    wb_lane_select #(
        .CSR_CAPABLE(1'b0)
    ) lane1_inst (
        .clk       (clk),
        .aresetn   (aresetn),
        .lane      (lane1_in),
        .units     (units),
        .allow_in  (allow_in),
        .wr        (wr1),
        .debug     (debug1),
        .wait_unit (wait1)
    );

    exc_commit exc_commit_inst (
        .clk           (clk),
        .aresetn       (aresetn),
        .exc           (exc),
        .cpu_interrupt (cpu_interrupt),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry),
        .commit        (commit),
        .entry_pc      (entry_pc)
    );

    regfile_2w4r regfile_inst (
        .clk     (clk),
        .aresetn (aresetn),
        .wr0     (wr0),
        .wr1     (wr1),
        .raddr   (raddr),
        .rdata   (rdata)
    );

endmodule

/* dv/wb_tests.svh */
task automatic reset_state();
    check_value(32'(debug0.rf_wen | debug1.rf_wen), 32'd0, "write enable after reset");
    check_value(32'(debug0.valid | debug1.valid), 32'd0, "debug valid after reset");
    verify_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "commit after reset");
endtask

task automatic execute_results();
    lane_in_t            l0;
    lane_in_t            l1;
    logic [`WB_XLEN-1:0] exp0;
    for (int i = 0; i < 8; i++) begin
        l0              = make_lane();
        l1              = make_lane();
        l0.result_valid = 1'b1;
        l1.result_valid = 1'b1;
        l0.result       = rand_bits(32);
        l1.result       = rand_bits(32);
        // one same-target pair, one write to r0
        if (i == 1) begin
            l1.rd = l0.rd;
        end
        if (i == 2) begin
            l0.rd = '0;
        end
        lane0_in = l0;
        lane1_in = l1;
        settle();
        check_value(32'(allow_in), 32'd1, "execute allow_in");
        wait_accept();
        compare_trace(debug0, l0, 1'b1, l0.result, "execute lane 0");
        compare_trace(debug1, l1, 1'b1, l1.result, "execute lane 1");
        exp0 = (l0.rd == l1.rd) ? l1.result : l0.result;
        if (l0.rd == '0) begin
            exp0 = '0;
        end
        idle_lanes();
        raddr[0] = l0.rd;
        raddr[1] = l1.rd;
        raddr[2] = '0;
        next_cycle();
        check_value(rdata[0], exp0, "execute read lane 0 target");
        check_value(rdata[1], l1.result, "execute read lane 1 target");
        check_value(rdata[2], 32'd0, "r0 read");
    end
endtask

task automatic divide_writeback();
    lane_in_t            ins;
    logic [`WB_XLEN-1:0] expected;
    for (int i = 0; i < 2; i++) begin
        idle_lanes();
        ins                 = make_lane();
        ins.uop.is_div      = 1'b1;
        ins.uop.cond[0]     = (i == 1);
        units.quotient      = rand_bits(32);
        units.remainder     = rand_bits(32);
        units.div_ready     = 1'b0;
        expected            = (i == 1) ? units.remainder : units.quotient;
        // quotient through lane 0, remainder through lane 1
        if (i == 0) begin
            lane0_in = ins;
        end else begin
            lane1_in = ins;
        end
        settle();
        repeat (4) begin
            check_value(32'(allow_in), 32'd0, "divide allow_in while busy");
            next_cycle();
            check_value(32'(debug0.rf_wen | debug1.rf_wen), 32'd0, "divide write while busy");
            check_value(32'(debug0.valid), 32'd0, "divide debug valid while busy");
        end
        units.div_ready = 1'b1;
        wait_accept();
        compare_trace((i == 0) ? debug0 : debug1, ins, 1'b1, expected, "divide");
        idle_lanes();
        units.div_ready = 1'b0;
        raddr[3]        = ins.rd;
        next_cycle();
        check_value(rdata[3], expected, "divide read back");
    end
endtask

task automatic load_store();
    lane_in_t            ld;
    lane_in_t            st;
    logic [`WB_XLEN-1:0] data;
    idle_lanes();
    ld                 = make_lane();
    ld.uop.is_mem      = 1'b1;
    lane1_in           = ld;
    units.dcache_data  = rand_bits(32);
    units.dcache_ready = 1'b0;
    data               = units.dcache_data;
    settle();
    repeat (3) begin
        check_value(32'(allow_in), 32'd0, "load allow_in while cache busy");
        next_cycle();
        check_value(32'(debug1.rf_wen), 32'd0, "load write while cache busy");
    end
    units.dcache_ready = 1'b1;
    wait_accept();
    compare_trace(debug1, ld, 1'b1, data, "load");
    // store while the cache is not ready
    idle_lanes();
    st                 = make_lane();
    st.uop.is_mem      = 1'b1;
    st.uop.cond[2]     = 1'b1;
    lane0_in           = st;
    units.dcache_ready = 1'b0;
    raddr[3]           = ld.rd;
    settle();
    check_value(32'(allow_in), 32'd1, "store allow_in");
    wait_accept();
    check_value(rdata[3], data, "load read back");
    compare_trace(debug0, st, 1'b0, 32'd0, "store");
endtask

task automatic csr_access();
    lane_in_t            op;
    lane_in_t            other;
    logic [`WB_XLEN-1:0] data;
    idle_lanes();
    op              = make_lane();
    op.uop.is_csr   = 1'b1;
    units.csr_data  = rand_bits(32);
    units.csr_ready = 1'b0;
    data            = units.csr_data;
    // lane 1 has no csr path
    lane1_in = op;
    settle();
    check_value(32'(allow_in), 32'd1, "csr on lane 1 allow_in");
    wait_accept();
    compare_trace(debug1, op, 1'b0, 32'd0, "csr on lane 1");
    other            = make_lane();
    other.uop.is_csr = 1'b1;
    lane0_in         = op;
    lane1_in         = other;
    settle();
    repeat (2) begin
        check_value(32'(allow_in), 32'd0, "csr allow_in while busy");
        next_cycle();
        check_value(32'(debug0.rf_wen), 32'd0, "csr write while busy");
    end
    units.csr_ready = 1'b1;
    wait_accept();
    compare_trace(debug0, op, 1'b1, data, "csr on lane 0");
    compare_trace(debug1, other, 1'b0, 32'd0, "csr pair on lane 1");
    idle_lanes();
    raddr[3] = op.rd;
    next_cycle();
    check_value(rdata[3], data, "csr read back");
endtask

task automatic exception_commit();
    ecode_e code;
    logic   badv_exp;
    logic   vppn_exp;
    string  tag;
    code = code.first();
    do begin
        exc.flag  = 1'b1;
        exc.ecode = code;
        exc.badv  = rand_bits(32);
        exc.era   = rand_bits(32);
        badv_exp  = code inside {PIL, PIS, PIF, PME, PPI, ADEF, ALE, TLBR};
        vppn_exp  = code inside {PIL, PIS, PIF, PME, PPI, TLBR};
        tag       = $sformatf("exception %s", code.name());
        next_cycle();
        verify_commit(1'b1, 1'b1, badv_exp, vppn_exp, code == TLBR, tag);
        check_value(32'(commit.ecode), 32'(code), {tag, ": ecode"});
        check_value(commit.badv, exc.badv, {tag, ": badv"});
        check_value(commit.era, exc.era, {tag, ": era"});
        check_value(32'(commit.vppn), 32'(exc.badv[18:0]), {tag, ": vppn"});
        code = code.next();
    end while (code != code.first());
    // flag low, code still TLBR
    exc.flag  = 1'b0;
    exc.ecode = TLBR;
    next_cycle();
    verify_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "exception cleared");
    cpu_interrupt = 1'b1;
    next_cycle();
    verify_commit(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, "interrupt");
    cpu_interrupt = 1'b0;
    next_cycle();
    verify_commit(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, "interrupt cleared");
endtask

task automatic debug_trace();
    lane_in_t l0;
    lane_in_t l1;
    l0              = make_lane();
    l0.result_valid = 1'b1;
    l0.result       = rand_bits(32);
    l1              = make_lane();
    lane0_in        = l0;
    lane1_in        = l1;
    wait_accept();
    compare_trace(debug0, l0, 1'b1, l0.result, "trace writing lane");
    compare_trace(debug1, l1, 1'b0, 32'd0, "trace silent lane");
    idle_lanes();
    l0 = lane0_in;
    l1 = lane1_in;
    next_cycle();
    compare_trace(debug0, l0, 1'b0, 32'd0, "trace idle lane 0");
    compare_trace(debug1, l1, 1'b0, 32'd0, "trace idle lane 1");
endtask

/* dv/wb_tb.sv */
`timescale 1ns/100ps
`include "wb_settings.svh"

module wb_tb;
    import wb_pkg::*;
    import exc_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 7;
    localparam int CYCLES_PER_TEST = 200;

    logic                        clk;
    logic                        aresetn;
    lane_in_t                    lane0_in;
    lane_in_t                    lane1_in;
    unit_res_t                   units;
    logic                        allow_in;
    exc_in_t                     exc;
    logic                        cpu_interrupt;
    logic [`WB_XLEN-1:0]         eentry;
    logic [`WB_XLEN-1:0]         tlbrentry;
    exc_commit_t                 commit;
    logic [`WB_XLEN-1:0]         entry_pc;
    logic [3:0][`WB_RADDR_W-1:0] raddr;
    logic [3:0][`WB_XLEN-1:0]    rdata;
    wb_debug_t                   debug0;
    wb_debug_t                   debug1;

    logic [31:0] lfsr_state;

    wb_top wb_top_inst (
        .clk           (clk),
        .aresetn       (aresetn),
        .lane0_in      (lane0_in),
        .lane1_in      (lane1_in),
        .units         (units),
        .allow_in      (allow_in),
        .exc           (exc),
        .cpu_interrupt (cpu_interrupt),
        .eentry        (eentry),
        .tlbrentry     (tlbrentry),
        .commit        (commit),
        .entry_pc      (entry_pc),
        .raddr         (raddr),
        .rdata         (rdata),
        .debug0        (debug0),
        .debug1        (debug1)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        assert (actual === expected) else begin
            $display("FAILED at %0t: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
        return val;
    endfunction

    // no source selected, rd never r0
    function automatic lane_in_t make_lane();
        lane_in_t l;
        l      = '0;
        l.pc   = rand_bits(32) & 32'hffff_fffc;
        l.inst = rand_bits(32);
        l.rd   = 5'(rand_bits(5));
        if (l.rd == '0) begin
            l.rd = 5'd1;
        end
        return l;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // let combinational outputs follow the new inputs
    task automatic settle();
        #1;
    endtask

    task automatic idle_lanes();
        lane0_in = make_lane();
        lane1_in = make_lane();
    endtask

    task automatic clear_inputs();
        idle_lanes();
        units         = '0;
        exc           = '0;
        cpu_interrupt = 1'b0;
        eentry        = 32'h1c00_8000;
        tlbrentry     = 32'h1c00_f000;
        raddr         = '0;
    endtask

    task automatic wait_accept();
        settle();
        while (!allow_in) begin
            next_cycle();
        end
        next_cycle();
    endtask

    task automatic compare_trace(input wb_debug_t d, input lane_in_t l, input logic exp_we,
                                 input logic [`WB_XLEN-1:0] exp_data, input string tag);
        check_value(32'(d.valid), 32'd1, {tag, ": debug valid"});
        check_value(d.pc, l.pc, {tag, ": debug pc"});
        check_value(d.inst, l.inst, {tag, ": debug inst"});
        check_value(32'(d.rf_wen), exp_we ? 32'hf : 32'h0, {tag, ": rf_wen"});
        if (exp_we) begin
            check_value(32'(d.rf_wnum), 32'(l.rd), {tag, ": rf_wnum"});
            check_value(d.rf_wdata, exp_data, {tag, ": rf_wdata"});
        end
    endtask

    task automatic verify_commit(input logic flush, input logic wen_era, input logic wen_badv,
                                 input logic wen_vppn, input logic refill, input string tag);
        check_value(32'(commit.flush), 32'(flush), {tag, ": flush"});
        check_value(32'(commit.wen_era), 32'(wen_era), {tag, ": wen_era"});
        check_value(32'(commit.wen_badv), 32'(wen_badv), {tag, ": wen_badv"});
        check_value(32'(commit.wen_vppn), 32'(wen_vppn), {tag, ": wen_vppn"});
        check_value(32'(commit.tlb_refill), 32'(refill), {tag, ": tlb_refill"});
        check_value(entry_pc, refill ? tlbrentry : eentry, {tag, ": entry_pc"});
    endtask

    `include "wb_tests.svh"

    // watchdog
    initial begin
        #(CLK_PERIOD * CYCLES_PER_TEST * NUM_TESTS);
        $display("Error: the tests did not finish in time, the simulation is stuck");
        abort_run();
    end

    initial begin
        lfsr_state = 32'hf3a8_da24;
        aresetn    = 1'b0;
        clear_inputs();
        repeat (3) @(posedge clk);
        #1;
        aresetn = 1'b1;
        reset_state();
        execute_results();
        divide_writeback();
        load_store();
        csr_access();
        exception_commit();
        debug_trace();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* flist.f */
+incdir+verilog
+incdir+dv
verilog/wb_pkg.sv
verilog/exc_pkg.sv
verilog/wb_lane_select.sv
verilog/exc_commit.sv
verilog/regfile_2w4r.sv
verilog/wb_top.sv
dv/wb_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert --timescale 1ns/100ps --top-module wb_tb -f flist.f -o wb_sim &&
./obj_dir/wb_sim 2>&1 | tee /dev/stderr | grep "All tests passed!" > /dev/null &&
echo "PASS" ||
{ echo "FAIL"; exit 1; }
